//--- hdl/arb_pkg.sv
`default_nettype none

package arb_pkg;

    // number of router ports sharing one output
    localparam int port_count = 8;

    // one bit per port
    // used for requests, grants, priority masks and the external priority
    typedef logic [port_count-1:0] port_vec_t;

    // reset value of the stored priority mask
    // all ones lets port 0 win first
    localparam port_vec_t mask_all_ones = '1;

    // inputs sampled together every cycle
    typedef struct packed {
        // level per port, held until granted
        port_vec_t request;
        // one-cycle strobe
        // moves the priority in the gated build
        logic      priority_en;
    } arb_req_t;

    // arbiter result, valid in the same cycle as the request
    typedef struct packed {
        // one-hot or zero
        port_vec_t grant;
        // high when any port is requesting
        logic      any_grant;
    } arb_grant_t;

    // prefix-OR thermometer code
    // bit i is set when any input bit at or below i is set
    // so the result is ones from the lowest set bit upwards
    // and all zeros for a zero input
    function automatic port_vec_t thermo(input port_vec_t vec);
        port_vec_t result;
        result[0] = vec[0];
        // ripple the OR upwards one position at a time
        for (int i = 1; i < port_count; i++) begin
            result[i] = result[i-1] | vec[i];
        end
        return result;
    endfunction

    // a thermometer XOR itself shifted up one place
    // leaves only its lowest set bit
    // a zero thermometer gives a zero result
    function automatic port_vec_t thermo_edge(input port_vec_t therm);
        port_vec_t shifted;
        shifted = {therm[port_count-2:0], 1'b0};
        return therm ^ shifted;
    endfunction

    // thermometer shifted up by one
    // ones strictly above the lowest set bit of the input code
    function automatic port_vec_t thermo_above(input port_vec_t therm);
        port_vec_t shifted;
        shifted = {therm[port_count-2:0], 1'b0};
        return shifted;
    endfunction

endpackage

`default_nettype wire

//--- hdl/rr_grant_logic.sv
`default_nettype none

// round-robin pick for the router ports
// purely combinational, grant appears in the same cycle as the request
//
// two thermometers are built
//   one of the raw request
//   one of the request restricted to the priority window
// the masked one wins whenever some request lies inside the window,
// otherwise the pick wraps around to the lowest requesting port
module rr_grant_logic (
    // request level per port
    input  wire arb_pkg::port_vec_t  request,
    // current priority window, thermometer coded
    input  wire arb_pkg::port_vec_t  prio_mask,
    // grant and any_grant
    output arb_pkg::arb_grant_t      gnt,
    // window for the next round, ones above the winner
    output arb_pkg::port_vec_t       next_mask
);

    // index of the most significant port
    localparam int top_bit = arb_pkg::port_count - 1;

    // requests inside the priority window
    arb_pkg::port_vec_t masked_request;

    // thermometer of every request
    arb_pkg::port_vec_t req_thermo;

    // thermometer of the windowed requests
    arb_pkg::port_vec_t masked_thermo;

    // high when at least one request sits inside the window
    logic               use_masked;

    // thermometer actually used for the pick
    arb_pkg::port_vec_t sel_thermo;

    // selected thermometer moved up one place
    arb_pkg::port_vec_t shifted_thermo;

    // one-hot winner
    arb_pkg::port_vec_t grant_vec;

    // restrict to ports at or above the rotating pointer
    assign masked_request = request & prio_mask;

    // prefix-OR of both request views
    assign req_thermo    = arb_pkg::thermo(request);
    assign masked_thermo = arb_pkg::thermo(masked_request);

    // a thermometer reaches its top bit iff its input is nonzero
    assign use_masked = masked_thermo[top_bit];

    // windowed pick first, wrap to the full request otherwise
    // when nothing is requested both are zero and so is the pick
    assign sel_thermo = use_masked ? masked_thermo : req_thermo;

    // ones strictly above the winner
    // becomes the window of the next round so the winner drops to last
    assign shifted_thermo = arb_pkg::thermo_above(sel_thermo);

    // isolate the lowest set bit of the chosen thermometer
    assign grant_vec = arb_pkg::thermo_edge(sel_thermo);

    // pack the result
    always_comb begin
        gnt.grant     = grant_vec;
        // top of the raw thermometer is the OR of all requests
        gnt.any_grant = req_thermo[top_bit];
    end

    // zero when nothing was granted
    // a strobe in that cycle clears the window and the lowest port goes next
    assign next_mask = shifted_thermo;

endmodule

`default_nettype wire

//--- hdl/rr_priority_state.sv
`default_nettype none

// priority pointer of the round-robin arbiter
// holds the thermometer window that the grant logic works from
//
// update rule fixed at build time
//   gated_update = 0  load on every cycle with a grant
//   gated_update = 1  load only on the priority_en strobe
//
// priority_ext_sel replaces the stored window with one built from
// priority_in, while the stored window still follows the issued grants
module rr_priority_state #(
    parameter bit gated_update = 1'b0
) (
    input  wire logic                clk,
    input  wire logic                reset,
    // some port requested this cycle
    input  wire logic                any_grant,
    // update strobe for the gated build
    input  wire logic                priority_en,
    // window derived from this cycle's winner
    input  wire arb_pkg::port_vec_t  next_mask,
    // level, picks the external window
    input  wire logic                priority_ext_sel,
    // external priority, lowest set bit marks the first port in line
    input  wire arb_pkg::port_vec_t  priority_in,
    // window handed to the grant logic
    output arb_pkg::port_vec_t       prio_mask
);

    // stored window
    arb_pkg::port_vec_t stored_mask;

    // load enable for the stored window
    logic               load_mask;

    // external window, ones at and above the lowest bit of priority_in
    arb_pkg::port_vec_t ext_mask;

    generate
        if (gated_update) begin : g_gated
            // pointer only moves when the router allows it
            // a strobe without any request clears the window
            assign load_mask = priority_en;
        end else begin : g_free
            // pointer moves after every issued grant
            // idle cycles leave it where it is
            assign load_mask = any_grant;
        end
    endgenerate

    // pointer register
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            // all ones, port 0 first after reset
            stored_mask <= arb_pkg::mask_all_ones;
        end else if (load_mask) begin
            // always from the grant actually issued,
            // also while the external window is in use
            stored_mask <= next_mask;
        end
    end

    // zero priority_in gives a zero window
    // the grant logic then falls back to the lowest request
    assign ext_mask = arb_pkg::thermo(priority_in);

    // window select
    always_comb begin
        if (priority_ext_sel) begin
            prio_mask = ext_mask;
        end else begin
            prio_mask = stored_mask;
        end
    end

endmodule

`default_nettype wire

//--- hdl/rr_arbiter.sv
`default_nettype none

// eight-port round-robin arbiter for a NoC router output
//
// request to grant is combinational
// the priority window is registered and rotates past each winner
//
// gated_update chooses when the window moves
//   0  on every cycle with a request
//   1  only on req.priority_en
//
// priority_ext_sel swaps in a window built from priority_in
// for as long as it is held high
module rr_arbiter #(
    parameter bit gated_update = 1'b0
) (
    input  wire logic                clk,
    // asynchronous, active high
    input  wire logic                reset,
    // request levels and priority_en strobe
    input  wire arb_pkg::arb_req_t   req,
    // level, use the external priority window
    input  wire logic                priority_ext_sel,
    // external priority vector
    input  wire arb_pkg::port_vec_t  priority_in,
    // one-hot grant and any_grant
    output wire arb_pkg::arb_grant_t gnt
);

    // window from the pointer block to the pick
    wire arb_pkg::port_vec_t prio_mask;

    // window for the next round, from the pick back to the pointer
    wire arb_pkg::port_vec_t next_mask;

    // combinational pick
    rr_grant_logic grant_logic_i (
        .request   (req.request),
        .prio_mask (prio_mask),
        .gnt       (gnt),
        .next_mask (next_mask)
    );

    // pointer register with its update rule
    // any_grant and priority_en are the two candidate strobes
    rr_priority_state #(
        .gated_update (gated_update)
    ) priority_state_i (
        .clk              (clk),
        .reset            (reset),
        .any_grant        (gnt.any_grant),
        .priority_en      (req.priority_en),
        .next_mask        (next_mask),
        .priority_ext_sel (priority_ext_sel),
        .priority_in      (priority_in),
        .prio_mask        (prio_mask)
    );

endmodule

`default_nettype wire

//--- verif/rr_arbiter_model.svh
`ifndef RR_ARBITER_MODEL_SVH
`define RR_ARBITER_MODEL_SVH

// model copy of the priority window
// tracks the DUT pointer register cycle by cycle
arb_pkg::port_vec_t model_mask;

// one-hot of the lowest set bit, zero for a zero input
function automatic arb_pkg::port_vec_t lowest_set(input arb_pkg::port_vec_t vec);
    arb_pkg::port_vec_t one_hot;
    bit                 found;
    one_hot = '0;
    found   = 1'b0;
    for (int i = 0; i < arb_pkg::port_count; i++) begin
        if (vec[i] && !found) begin
            one_hot[i] = 1'b1;
            found      = 1'b1;
        end
    end
    return one_hot;
endfunction

// ones at and above the lowest set bit
function automatic arb_pkg::port_vec_t ones_from_lowest(input arb_pkg::port_vec_t vec);
    arb_pkg::port_vec_t result;
    bit                 seen;
    seen = 1'b0;
    for (int i = 0; i < arb_pkg::port_count; i++) begin
        if (vec[i]) begin
            seen = 1'b1;
        end
        result[i] = seen;
    end
    return result;
endfunction

// ones strictly above the granted port
function automatic arb_pkg::port_vec_t ones_above(input arb_pkg::port_vec_t one_hot);
    arb_pkg::port_vec_t result;
    bit                 seen;
    seen = 1'b0;
    for (int i = 0; i < arb_pkg::port_count; i++) begin
        result[i] = seen;
        if (one_hot[i]) begin
            seen = 1'b1;
        end
    end
    return result;
endfunction

// expected pick for this cycle's inputs
function automatic arb_pkg::port_vec_t expected_grant(input arb_pkg::port_vec_t request,
                                                      input logic ext_sel,
                                                      input arb_pkg::port_vec_t prio_in);
    arb_pkg::port_vec_t window;
    window = ext_sel ? ones_from_lowest(prio_in) : model_mask;
    // windowed requests first, else wrap to the lowest request
    if ((request & window) != '0) begin
        return lowest_set(request & window);
    end
    return lowest_set(request);
endfunction

// model pointer update at the coming rising edge
task automatic model_advance(input arb_pkg::port_vec_t request, input logic prio_en,
                             input logic ext_sel, input arb_pkg::port_vec_t prio_in);
    arb_pkg::port_vec_t grant;
    logic               load;
    grant = expected_grant(request, ext_sel, prio_in);
    // strobe follows the build's update rule
    load  = gated_update ? prio_en : (request != '0);
    if (load) begin
        model_mask = ones_above(grant);
    end
endtask

task automatic abort_run();
    $display("TESTS FAILED");
    $fatal(1, "simulation stopped at the first failure");
endtask

task automatic check_grant(input string test_name, input arb_pkg::port_vec_t expected,
                           input arb_pkg::port_vec_t actual);
    if (actual !== expected) begin
        $display("** Error in %s: expected grant %b, actual %b", test_name, expected, actual);
        abort_run();
    end
endtask

task automatic check_any(input string test_name, input logic expected, input logic actual);
    if (actual !== expected) begin
        $display("** Error in %s: expected any_grant %b, actual %b", test_name, expected, actual);
        abort_run();
    end
endtask

`endif

//--- verif/rr_arbiter_tb.sv
`default_nettype none

module rr_arbiter_tb #(
    parameter bit gated_update = 1'b0
);

    localparam int half_period     = 50;
    // sample point shortly before the rising edge
    localparam int sample_delay    = 40;
    localparam int reset_cycles    = 8;
    localparam int rotate_cycles   = 16;
    localparam int random_cycles   = 1000;
    localparam int external_cycles = 500;
    // about 1,530 cycles of tests plus margin
    localparam int timeout_cycles  = 2500;

    logic                clk;
    logic                reset;
    arb_pkg::arb_req_t   req;
    logic                priority_ext_sel;
    arb_pkg::port_vec_t  priority_in;
    wire arb_pkg::arb_grant_t gnt;

    int                  cycle_count;

    `include "rr_arbiter_model.svh"

    rr_arbiter #(
        .gated_update (gated_update)
    ) dut_i (
        .clk              (clk),
        .reset            (reset),
        .req              (req),
        .priority_ext_sel (priority_ext_sel),
        .priority_in      (priority_in),
        .gnt              (gnt)
    );

    always #half_period clk = ~clk;

    // run limit
    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            $display("timeout, run went past %0d clock cycles", timeout_cycles);
            abort_run();
        end
    end

    // grant must be one-hot or zero and only go to requesting ports
    task automatic check_legal(input string test_name);
        if ($countones(gnt.grant) > 1) begin
            $display("%s: grant has more than one bit set (%b)", test_name, gnt.grant);
            abort_run();
        end
        if ((gnt.grant & ~req.request) != '0) begin
            $display("%s: grant %b goes to a port that is not requesting", test_name,
                     gnt.grant);
            abort_run();
        end
    endtask

    // drive on the falling edge and check just before the rising edge
    task automatic drive_and_check(input string test_name, input arb_pkg::port_vec_t request,
                                   input logic prio_en, input logic ext_sel,
                                   input arb_pkg::port_vec_t prio_in);
        @(negedge clk);
        req.request      = request;
        req.priority_en  = prio_en;
        priority_ext_sel = ext_sel;
        priority_in      = prio_in;
        #sample_delay;
        check_grant(test_name, expected_grant(request, ext_sel, prio_in), gnt.grant);
        check_any(test_name, request != '0, gnt.any_grant);
        check_legal(test_name);
        // model state for the coming edge
        model_advance(request, prio_en, ext_sel, prio_in);
    endtask

    // random port vector, sometimes sparse
    function automatic arb_pkg::port_vec_t random_vec();
        int unsigned r;
        r = $urandom();
        if (r[9:8] == 2'b00) begin
            return r[7:0] & r[15:8] & r[23:16];
        end
        return r[arb_pkg::port_count-1:0];
    endfunction

    function automatic logic random_bit();
        int unsigned r;
        r = $urandom();
        return r[0];
    endfunction

    initial begin
        arb_pkg::port_vec_t expected;
        arb_pkg::port_vec_t idle_expect;
        void'($urandom(32'hfcea_5ba2));
        clk              = 1'b0;
        reset            = 1'b1;
        req              = '0;
        priority_ext_sel = 1'b0;
        priority_in      = '0;
        cycle_count      = 0;
        model_mask       = arb_pkg::mask_all_ones;

        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // all ports requesting, port 0 first then one step per cycle
        for (int i = 0; i < rotate_cycles; i++) begin
            expected                         = '0;
            expected[i % arb_pkg::port_count] = 1'b1;
            drive_and_check("rotate_after_reset", '1, 1'b1, 1'b0, '0);
            check_grant("rotate_after_reset", expected, gnt.grant);
        end

        // random requests and strobes against the model
        for (int i = 0; i < random_cycles; i++) begin
            drive_and_check("random_requests", random_vec(), random_bit(), 1'b0, '0);
        end

        // only port 2 requesting, window becomes ones above port 2
        drive_and_check("idle_setup", 8'b0000_0100, 1'b1, 1'b0, '0);
        check_grant("idle_setup", 8'b0000_0100, gnt.grant);
        // idle cycle with a strobe
        drive_and_check("idle_no_request", '0, 1'b1, 1'b0, '0);
        check_grant("idle_no_request", '0, gnt.grant);
        check_any("idle_no_request", 1'b0, gnt.any_grant);
        // gated build cleared the window, free build kept it
        idle_expect = gated_update ? 8'b0000_0001 : 8'b0000_1000;
        drive_and_check("idle_next_pick", '1, 1'b0, 1'b0, '0);
        check_grant("idle_next_pick", idle_expect, gnt.grant);

        // external priority window
        for (int i = 0; i < external_cycles; i++) begin
            drive_and_check("external_priority", random_vec(), random_bit(), 1'b1,
                            random_vec());
        end

        // back on the stored window
        // all ports requesting exposes where the pointer moved to meanwhile
        drive_and_check("after_external", '1, 1'b0, 1'b0, '0);

        $display("TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+verif
hdl/arb_pkg.sv
hdl/rr_grant_logic.sv
hdl/rr_priority_state.sv
hdl/rr_arbiter.sv
verif/rr_arbiter_tb.sv

//--- run.sh
#!/bin/sh
# builds and runs the testbench once per update rule
# free-running build first, then the gated build
verilator --binary -f verilog.f --top-module rr_arbiter_tb \
    -Ggated_update=0 --Mdir obj_dir_free -o sim_free &&
./obj_dir_free/sim_free &&
verilator --binary -f verilog.f --top-module rr_arbiter_tb \
    -Ggated_update=1 --Mdir obj_dir_gated -o sim_gated &&
./obj_dir_gated/sim_gated ||
{ echo "simulation failed"; exit 1; }
exit 0
